//--- Makefile
# Verilator build and run for the gp register subsystem

VERILATOR  ?= verilator
FILELIST   := vlog.f
TOP        := tb_gpreg
RTL_TOP    := gpreg_top
OBJ_DIR    := obj_dir
SIM_FLAGS  := --binary --timing --assert -j 0 -Wno-fatal
LINT_FLAGS := --lint-only --timing -Wall
PASS_MSG   := Testbench passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# the pass line in the output decides the result
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

//--- sim/tb_clk_gen.sv
// ******************************
// free running testbench clock, period set per instance
// ******************************

module tb_clk_gen #(
  parameter int unsigned period_ns = 10
) (
  output logic clk
);

  timeunit 1ns;
  timeprecision 100ps;

  // starts low, first rise after half a period
  initial begin
    clk = 1'b0;
    forever begin
      #(real'(period_ns) / 2.0);
      clk = ~clk;
    end
  end

endmodule

//--- sim/tb_gpreg.sv
// ******************************
// directed testbench for the gp register subsystem
// drives the up bus on falling edges, checks responses, prints a summary
// ******************************

module tb_gpreg;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int unsigned aw = gpreg_map_pkg::addr_w;
  localparam int unsigned dw = gpreg_map_pkg::data_w;
  localparam int unsigned bw = gpreg_map_pkg::blk_w;
  localparam int unsigned ow = gpreg_map_pkg::blk_lsb;
  localparam int unsigned cw = gpreg_clkmon_pkg::cm_count_w;
  localparam int unsigned win = gpreg_clkmon_pkg::cm_window;

  localparam int unsigned up_period_ns = 10;
  localparam int unsigned mon_period_ns = 4;
  // mon_clk edges in one up_clk window
  localparam int unsigned exp_count = win * up_period_ns / mon_period_ns;
  // monitor test is about five windows, bus tests a few hundred cycles
  localparam int unsigned max_cycles = 6000;

  // register addresses
  localparam logic [aw-1:0] enb_addr = {gpreg_map_pkg::io_id, gpreg_map_pkg::io_reg_enb};
  localparam logic [aw-1:0] out_addr = {gpreg_map_pkg::io_id, gpreg_map_pkg::io_reg_out};
  localparam logic [aw-1:0] in_addr = {gpreg_map_pkg::io_id, gpreg_map_pkg::io_reg_in};
  localparam logic [aw-1:0] ctrl_addr = {gpreg_map_pkg::clk_mon_id, gpreg_map_pkg::cm_reg_ctrl};
  localparam logic [aw-1:0] count_addr = {gpreg_map_pkg::clk_mon_id, gpreg_map_pkg::cm_reg_count};

  logic          up_clk;
  logic          mon_clk;
  logic          up_rstn;
  logic          up_wreq;
  logic [aw-1:0] up_waddr;
  logic [dw-1:0] up_wdata;
  logic          up_wack;
  logic          up_rreq;
  logic [aw-1:0] up_raddr;
  logic [dw-1:0] up_rdata;
  logic          up_rack;
  logic [dw-1:0] up_gp_in;
  logic [dw-1:0] up_gp_ioenb;
  logic [dw-1:0] up_gp_out;

  int unsigned data_errors = 0;
  int unsigned count_errors = 0;
  int unsigned bus_errors = 0;
  int unsigned cycles = 0;

  tb_clk_gen #(.period_ns(up_period_ns)) i_up_clk_gen (.clk(up_clk));
  tb_clk_gen #(.period_ns(mon_period_ns)) i_mon_clk_gen (.clk(mon_clk));

  gpreg_top i_gpreg_top (
    .up_clk      (up_clk),
    .up_rstn     (up_rstn),
    .up_wreq     (up_wreq),
    .up_waddr    (up_waddr),
    .up_wdata    (up_wdata),
    .up_wack     (up_wack),
    .up_rreq     (up_rreq),
    .up_raddr    (up_raddr),
    .up_rdata    (up_rdata),
    .up_rack     (up_rack),
    .up_gp_in    (up_gp_in),
    .up_gp_ioenb (up_gp_ioenb),
    .up_gp_out   (up_gp_out),
    .mon_clk     (mon_clk)
  );

  // ******************************
  // compare and bus helpers
  // ******************************

  task automatic check_data(input string name, input logic [dw-1:0] exp, input logic [dw-1:0] act);
    if (act !== exp) begin
      data_errors++;
      $display("[ERROR] %s: expected 0x%h, actual 0x%h", name, exp, act);
    end
  endtask

  task automatic check_count(input string name, input logic [cw-1:0] exp,
                             input logic [cw-1:0] act, input int tol);
    int diff;
    diff = int'(act) - int'(exp);
    if ($isunknown(act) || diff > tol || diff < -tol) begin
      count_errors++;
      $display("[ERROR] %s: expected %0d (+/- %0d), actual %0d", name, exp, tol, act);
    end
  endtask

  task automatic bus_error(input string name, input string what);
    bus_errors++;
    $display("%s: %s", name, what);
  endtask

  // entered just after a falling edge, returns on the edge that shows the ack
  task automatic bus_write(input string name, input logic [aw-1:0] addr,
                           input logic [dw-1:0] data);
    up_wreq = 1'b1;
    up_waddr = addr;
    up_wdata = data;
    @(negedge up_clk);
    up_wreq = 1'b0;
    // block stage has it, merge stage not yet
    if (up_wack !== 1'b0) bus_error(name, "write acknowledge came early");
    @(negedge up_clk);
    if (up_wack !== 1'b1) bus_error(name, "no write acknowledge two cycles after the request");
  endtask

  task automatic bus_read(input string name, input logic [aw-1:0] addr,
                          output logic [dw-1:0] data);
    up_rreq = 1'b1;
    up_raddr = addr;
    @(negedge up_clk);
    up_rreq = 1'b0;
    if (up_rack !== 1'b0) bus_error(name, "read acknowledge came early");
    @(negedge up_clk);
    if (up_rack !== 1'b1) bus_error(name, "no read acknowledge two cycles after the request");
    data = up_rdata;
  endtask

  // one strobe, then four cycles of silence on the response side
  task automatic expect_silence(input string name, input bit is_write,
                                input logic [aw-1:0] addr, input logic [dw-1:0] data);
    if (is_write) begin
      up_wreq = 1'b1;
      up_waddr = addr;
      up_wdata = data;
    end else begin
      up_rreq = 1'b1;
      up_raddr = addr;
    end
    @(negedge up_clk);
    up_wreq = 1'b0;
    up_rreq = 1'b0;
    repeat (4) begin
      if (up_wack || up_rack) bus_error(name, "an unmapped block was acknowledged");
      if (up_rdata !== '0) bus_error(name, "read data changed for an unmapped block");
      @(negedge up_clk);
    end
  endtask

  // requests on consecutive cycles, each ack due two falling edges after its drive
  task automatic run_burst(input string name, input bit is_write, input int n,
                           input logic [aw-1:0] addrs [5], input logic [dw-1:0] vals [5]);
    logic ack;
    bit   due;
    for (int j = 0; j < n + 3; j++) begin
      due = (j >= 2) && (j < n + 2);
      ack = is_write ? up_wack : up_rack;
      if (ack !== due) begin
        bus_error(name, $sformatf("acknowledge was %0b at step %0d, should be %0b", ack, j, due));
      end
      if (due && !is_write) check_data(name, vals[j-2], up_rdata);
      up_wreq = 1'b0;
      up_rreq = 1'b0;
      if (j < n) begin
        if (is_write) begin
          up_wreq = 1'b1;
          up_waddr = addrs[j];
          up_wdata = vals[j];
        end else begin
          up_rreq = 1'b1;
          up_raddr = addrs[j];
        end
      end
      @(negedge up_clk);
    end
  endtask

  // ******************************
  // directed tests
  // ******************************

  task automatic test_reset_values();
    logic [dw-1:0] rd;
    check_data("reset ioenb port", '1, up_gp_ioenb);
    check_data("reset out port", '0, up_gp_out);
    bus_read("reset enb read", enb_addr, rd);
    check_data("reset enb read", '1, rd);
    bus_read("reset out read", out_addr, rd);
    check_data("reset out read", '0, rd);
    bus_read("reset ctrl read", ctrl_addr, rd);
    check_data("reset ctrl read", 32'h1, rd);
    bus_read("reset count read", count_addr, rd);
    check_count("reset count read", '0, rd[cw-1:0], 0);
  endtask

  task automatic test_gpio_write_read();
    logic [dw-1:0] enb;
    logic [dw-1:0] out;
    logic [dw-1:0] rd;
    repeat (4) begin
      enb = $urandom();
      out = $urandom();
      bus_write("gpio enb write", enb_addr, enb);
      bus_write("gpio out write", out_addr, out);
      check_data("gpio ioenb port", enb, up_gp_ioenb);
      check_data("gpio out port", out, up_gp_out);
      bus_read("gpio enb read", enb_addr, rd);
      check_data("gpio enb read", enb, rd);
      bus_read("gpio out read", out_addr, rd);
      check_data("gpio out read", out, rd);
    end
  endtask

  task automatic test_gpio_input();
    logic [dw-1:0] pins;
    logic [dw-1:0] rd;
    repeat (3) begin
      pins = $urandom();
      up_gp_in = pins;
      // let the synchronizer settle
      repeat (gpreg_clkmon_pkg::cm_sync_stages + 1) @(negedge up_clk);
      bus_read("gpio input read", in_addr, rd);
      check_data("gpio input read", pins, rd);
    end
  endtask

  task automatic test_unmapped();
    logic [dw-1:0] rd;
    logic [dw-1:0] enb_before;
    logic [dw-1:0] out_before;
    bus_read("gpio offset 7", {gpreg_map_pkg::io_id, ow'(7)}, rd);
    check_data("gpio offset 7", '0, rd);
    bus_read("gpio offset 15", {gpreg_map_pkg::io_id, ow'(15)}, rd);
    check_data("gpio offset 15", '0, rd);
    // known pin state before the stray requests
    enb_before = $urandom();
    out_before = $urandom();
    bus_write("block 5 setup enb", enb_addr, enb_before);
    bus_write("block 5 setup out", out_addr, out_before);
    // same offsets as the gpio registers, only the block number is wrong
    expect_silence("block 5 write", 1'b1, {bw'(5), gpreg_map_pkg::io_reg_out}, $urandom());
    expect_silence("block 5 enb write", 1'b1, {bw'(5), gpreg_map_pkg::io_reg_enb}, $urandom());
    expect_silence("block 5 read", 1'b0, {bw'(5), gpreg_map_pkg::io_reg_in}, '0);
    check_data("block 5 ioenb port", enb_before, up_gp_ioenb);
    check_data("block 5 out port", out_before, up_gp_out);
  endtask

  task automatic test_clk_mon();
    logic [dw-1:0] rd;
    // held since reset
    repeat (2 * win) @(negedge up_clk);
    bus_read("clk_mon held ctrl", ctrl_addr, rd);
    check_data("clk_mon held ctrl", 32'h1, rd);
    bus_read("clk_mon held count", count_addr, rd);
    check_count("clk_mon held count", '0, rd[cw-1:0], 0);
    bus_write("clk_mon release", ctrl_addr, '0);
    bus_read("clk_mon run ctrl", ctrl_addr, rd);
    check_data("clk_mon run ctrl", '0, rd);
    // first window may be short, later ones are full
    repeat (3 * win) @(negedge up_clk);
    bus_read("clk_mon count", count_addr, rd);
    check_count("clk_mon count", cw'(exp_count), rd[cw-1:0], 2);
    check_data("clk_mon count upper bits", '0, rd >> cw);
  endtask

  task automatic test_back_to_back();
    logic [aw-1:0] addrs [5];
    logic [dw-1:0] vals [5];
    logic [dw-1:0] out_val;
    logic [dw-1:0] enb_val;
    out_val = $urandom();
    enb_val = $urandom();
    // alternate blocks, monitor goes back on hold
    addrs = '{out_addr, ctrl_addr, enb_addr, out_addr, out_addr};
    vals = '{out_val, 32'h1, enb_val, '0, '0};
    run_burst("b2b writes", 1'b1, 3, addrs, vals);
    check_data("b2b out port", out_val, up_gp_out);
    check_data("b2b ioenb port", enb_val, up_gp_ioenb);
    // held monitor reads count zero
    addrs = '{out_addr, ctrl_addr, enb_addr, count_addr, in_addr};
    vals = '{out_val, 32'h1, enb_val, '0, up_gp_in};
    run_burst("b2b reads", 1'b0, 5, addrs, vals);
  endtask

  // ******************************
  // run control
  // ******************************

  always @(posedge up_clk) begin
    cycles <= cycles + 1;
    if (cycles >= max_cycles) begin
      $display("timeout: tests still running after %0d up_clk cycles", max_cycles);
      $display("Testbench failed");
      $finish;
    end
  end

  initial begin
    void'($urandom(32'hc51f075f));
    up_rstn = 1'b0;
    up_wreq = 1'b0;
    up_waddr = '0;
    up_wdata = '0;
    up_rreq = 1'b0;
    up_raddr = '0;
    up_gp_in = '0;
    repeat (3) @(posedge up_clk);
    @(negedge up_clk);
    up_rstn = 1'b1;

    test_reset_values();
    test_gpio_write_read();
    test_gpio_input();
    test_unmapped();
    test_clk_mon();
    test_back_to_back();

    $display("errors: data %0d, count %0d, bus %0d", data_errors, count_errors, bus_errors);
    if (data_errors + count_errors + bus_errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

//--- src/gpreg_clk_mon.sv
// ******************************
// clock monitor, counts mon_clk edges per fixed up_clk window
// control bit 0 holds it in reset, count register reads the last window
// ******************************

module gpreg_clk_mon (
  input  logic                             up_clk,
  input  logic                             up_rstn,
  // write request
  input  logic                             up_wreq,
  input  logic [gpreg_map_pkg::addr_w-1:0] up_waddr,
  input  logic [gpreg_map_pkg::data_w-1:0] up_wdata,
  // read request
  input  logic                             up_rreq,
  input  logic [gpreg_map_pkg::addr_w-1:0] up_raddr,
  // clock under measurement
  input  logic                             mon_clk,
  // local response toward the merge
  output logic                             cm_wack,
  output logic                             cm_rack,
  output logic [gpreg_map_pkg::data_w-1:0] cm_rdata
);

  localparam int unsigned ns = gpreg_clkmon_pkg::cm_sync_stages;

  // up domain
  logic                                     wreq_s;
  logic                                     rreq_s;
  logic [gpreg_map_pkg::blk_lsb-1:0]        woff;
  logic [gpreg_map_pkg::blk_lsb-1:0]        roff;
  logic                                     mon_hold;
  logic [gpreg_clkmon_pkg::cm_win_w-1:0]    win_cnt;
  logic                                     req_tgl;
  logic [ns-1:0]                            ack_sync;
  logic                                     ack_sync_d;
  logic                                     req_busy;
  logic                                     ack_edge;
  logic [gpreg_clkmon_pkg::cm_count_w-1:0]  up_count;
  // mon domain
  logic [ns-1:0]                            mon_rst_sync;
  logic                                     mon_rst;
  logic [ns-1:0]                            mon_req_sync;
  logic                                     mon_req_d;
  logic                                     mon_req_edge;
  logic                                     mon_ack_tgl;
  logic [gpreg_clkmon_pkg::cm_count_w-1:0]  mon_cnt;
  logic [gpreg_clkmon_pkg::cm_count_w-1:0]  mon_cap;

  // block decode
  assign wreq_s = up_wreq &&
    (up_waddr[gpreg_map_pkg::addr_w-1:gpreg_map_pkg::blk_lsb] == gpreg_map_pkg::clk_mon_id);
  assign rreq_s = up_rreq &&
    (up_raddr[gpreg_map_pkg::addr_w-1:gpreg_map_pkg::blk_lsb] == gpreg_map_pkg::clk_mon_id);
  assign woff = up_waddr[gpreg_map_pkg::blk_lsb-1:0];
  assign roff = up_raddr[gpreg_map_pkg::blk_lsb-1:0];

  // ******************************
  // bus registers
  // ******************************

  always_ff @(posedge up_clk) begin
    if (!up_rstn) begin
      cm_wack <= 1'b0;
      mon_hold <= gpreg_map_pkg::cm_ctrl_rst;
    end else begin
      cm_wack <= wreq_s;
      if (wreq_s && (woff == gpreg_map_pkg::cm_reg_ctrl)) begin
        mon_hold <= up_wdata[0];
      end
    end
  end

  always_ff @(posedge up_clk) begin
    if (!up_rstn) begin
      cm_rack <= 1'b0;
      cm_rdata <= '0;
    end else begin
      cm_rack <= rreq_s;
      cm_rdata <= '0;
      if (rreq_s && (roff == gpreg_map_pkg::cm_reg_ctrl)) begin
        cm_rdata <= {{(gpreg_map_pkg::data_w-1){1'b0}}, mon_hold};
      end
      if (rreq_s && (roff == gpreg_map_pkg::cm_reg_count)) begin
        cm_rdata <= {{(gpreg_map_pkg::data_w-gpreg_clkmon_pkg::cm_count_w){1'b0}}, up_count};
      end
    end
  end

  // ******************************
  // up side of the handshake
  // ******************************

  // request still waiting for its return toggle
  assign req_busy = req_tgl ^ ack_sync[ns-1];
  assign ack_edge = ack_sync[ns-1] ^ ack_sync_d;

  always_ff @(posedge up_clk) begin
    if (!up_rstn || mon_hold) begin
      win_cnt <= '0;
      req_tgl <= 1'b0;
      ack_sync <= '0;
      ack_sync_d <= 1'b0;
      up_count <= '0;
    end else begin
      ack_sync <= {ack_sync[ns-2:0], mon_ack_tgl};
      ack_sync_d <= ack_sync[ns-1];
      // window end, ask mon side for a capture
      if (win_cnt == gpreg_clkmon_pkg::cm_win_last) begin
        win_cnt <= '0;
        if (!req_busy) begin
          req_tgl <= ~req_tgl;
        end
      end else begin
        win_cnt <= win_cnt + 1'b1;
      end
      // mon_cap is stable once the return toggle is seen
      if (ack_edge) begin
        up_count <= mon_cap;
      end
    end
  end

  // ******************************
  // mon_clk side
  // ******************************

  // hold bit into mon_clk
  always_ff @(posedge mon_clk) begin
    mon_rst_sync <= {mon_rst_sync[ns-2:0], mon_hold};
  end

  assign mon_rst = mon_rst_sync[ns-1];
  assign mon_req_edge = mon_req_sync[ns-1] ^ mon_req_d;

  always_ff @(posedge mon_clk) begin
    if (mon_rst) begin
      mon_req_sync <= '0;
      mon_req_d <= 1'b0;
      mon_ack_tgl <= 1'b0;
      mon_cnt <= '0;
      mon_cap <= '0;
    end else begin
      mon_req_sync <= {mon_req_sync[ns-2:0], req_tgl};
      mon_req_d <= mon_req_sync[ns-1];
      if (mon_req_edge) begin
        // capture and restart, this edge is the first of the next window
        mon_cap <= mon_cnt;
        mon_cnt <= gpreg_clkmon_pkg::cm_count_w'(1);
        mon_ack_tgl <= ~mon_ack_tgl;
      end else if (mon_cnt != '1) begin
        mon_cnt <= mon_cnt + 1'b1;
      end
    end
  end

  // return toggle only moves to answer an outstanding request
  a_cm_ack_after_req: assert property (
    @(posedge up_clk) disable iff (!up_rstn || mon_hold)
    $changed(ack_sync[ns-1]) |-> $past(req_tgl != ack_sync[ns-1])
  );

endmodule

//--- src/gpreg_clkmon_pkg.sv
// ******************************
// clock measurement constants, shared by the monitor and the gpio input sync
// ******************************

package gpreg_clkmon_pkg;

  // up_clk cycles per measurement window
  localparam int unsigned cm_window = 256;

  // window counter width and its last value
  localparam int unsigned cm_win_w = $clog2(cm_window);
  localparam logic [cm_win_w-1:0] cm_win_last = cm_win_w'(cm_window - 1);

  // mon_clk count width, saturates at all ones
  localparam int unsigned cm_count_w = 16;

  // flops per synchronizer chain
  localparam int unsigned cm_sync_stages = 2;

endpackage

//--- src/gpreg_io.sv
// ******************************
// gpio block, enable and output registers plus a synchronized input readback
// answers block number io_id on the up bus
// ******************************

module gpreg_io (
  input  logic                             up_clk,
  input  logic                             up_rstn,
  // write request
  input  logic                             up_wreq,
  input  logic [gpreg_map_pkg::addr_w-1:0] up_waddr,
  input  logic [gpreg_map_pkg::data_w-1:0] up_wdata,
  // read request
  input  logic                             up_rreq,
  input  logic [gpreg_map_pkg::addr_w-1:0] up_raddr,
  // pins, asynchronous to up_clk
  input  logic [gpreg_map_pkg::data_w-1:0] up_gp_in,
  output logic [gpreg_map_pkg::data_w-1:0] up_gp_ioenb,
  output logic [gpreg_map_pkg::data_w-1:0] up_gp_out,
  // local response toward the merge
  output logic                             io_wack,
  output logic                             io_rack,
  output logic [gpreg_map_pkg::data_w-1:0] io_rdata
);

  logic                              wreq_s;
  logic                              rreq_s;
  logic [gpreg_map_pkg::blk_lsb-1:0] woff;
  logic [gpreg_map_pkg::blk_lsb-1:0] roff;
  logic [gpreg_map_pkg::data_w-1:0]  gp_in_sync [gpreg_clkmon_pkg::cm_sync_stages];

  // block decode
  assign wreq_s = up_wreq &&
    (up_waddr[gpreg_map_pkg::addr_w-1:gpreg_map_pkg::blk_lsb] == gpreg_map_pkg::io_id);
  assign rreq_s = up_rreq &&
    (up_raddr[gpreg_map_pkg::addr_w-1:gpreg_map_pkg::blk_lsb] == gpreg_map_pkg::io_id);

  // register offsets
  assign woff = up_waddr[gpreg_map_pkg::blk_lsb-1:0];
  assign roff = up_raddr[gpreg_map_pkg::blk_lsb-1:0];

  // input pin synchronizer
  always_ff @(posedge up_clk) begin
    gp_in_sync[0] <= up_gp_in;
    for (int i = 1; i < gpreg_clkmon_pkg::cm_sync_stages; i++) begin
      gp_in_sync[i] <= gp_in_sync[i-1];
    end
  end

  // ******************************
  // write side
  // ******************************

  always_ff @(posedge up_clk) begin
    if (!up_rstn) begin
      io_wack <= 1'b0;
      up_gp_ioenb <= gpreg_map_pkg::io_enb_rst;
      up_gp_out <= '0;
    end else begin
      // ack any decoded write, mapped or not
      io_wack <= wreq_s;
      if (wreq_s && (woff == gpreg_map_pkg::io_reg_enb)) begin
        up_gp_ioenb <= up_wdata;
      end
      if (wreq_s && (woff == gpreg_map_pkg::io_reg_out)) begin
        up_gp_out <= up_wdata;
      end
    end
  end

  // ******************************
  // read side
  // ******************************

  always_ff @(posedge up_clk) begin
    if (!up_rstn) begin
      io_rack <= 1'b0;
      io_rdata <= '0;
    end else begin
      io_rack <= rreq_s;
      if (rreq_s) begin
        case (roff)
          gpreg_map_pkg::io_reg_enb: io_rdata <= up_gp_ioenb;
          gpreg_map_pkg::io_reg_out: io_rdata <= up_gp_out;
          gpreg_map_pkg::io_reg_in:  io_rdata <= gp_in_sync[gpreg_clkmon_pkg::cm_sync_stages-1];
          default:                   io_rdata <= '0;
        endcase
      end else begin
        // idle data stays zero so the merge can simply or
        io_rdata <= '0;
      end
    end
  end

endmodule

//--- src/gpreg_map_pkg.sv
// ******************************
// bus widths, block numbers and register map of the gp register subsystem
// blocks refer to these by scoped name
// ******************************

package gpreg_map_pkg;

  // processor bus widths
  localparam int unsigned addr_w = 14;
  localparam int unsigned data_w = 32;

  // upper address bits pick the block, lower bits the register
  localparam int unsigned blk_lsb = 4;
  localparam int unsigned blk_w = addr_w - blk_lsb;

  // block numbers
  localparam logic [blk_w-1:0] io_id = blk_w'(0);
  localparam logic [blk_w-1:0] clk_mon_id = blk_w'(1);

  // gpio register offsets
  localparam logic [blk_lsb-1:0] io_reg_enb = blk_lsb'(0);
  localparam logic [blk_lsb-1:0] io_reg_out = blk_lsb'(1);
  localparam logic [blk_lsb-1:0] io_reg_in = blk_lsb'(2);

  // clock monitor register offsets
  localparam logic [blk_lsb-1:0] cm_reg_ctrl = blk_lsb'(0);
  localparam logic [blk_lsb-1:0] cm_reg_count = blk_lsb'(1);

  // reset values
  // all pins start as inputs
  localparam logic [data_w-1:0] io_enb_rst = '1;
  // monitor comes up held
  localparam logic cm_ctrl_rst = 1'b1;

endpackage

//--- src/gpreg_rd_merge.sv
// ******************************
// merges the block responses into one registered up bus response
// ******************************

module gpreg_rd_merge (
  input  logic                             up_clk,
  input  logic                             up_rstn,
  // gpio block
  input  logic                             io_wack,
  input  logic                             io_rack,
  input  logic [gpreg_map_pkg::data_w-1:0] io_rdata,
  // clock monitor
  input  logic                             cm_wack,
  input  logic                             cm_rack,
  input  logic [gpreg_map_pkg::data_w-1:0] cm_rdata,
  // bus response
  output logic                             up_wack,
  output logic                             up_rack,
  output logic [gpreg_map_pkg::data_w-1:0] up_rdata
);

  // blocks drive zero when idle, so a plain or is enough
  always_ff @(posedge up_clk) begin
    if (!up_rstn) begin
      up_wack <= 1'b0;
      up_rack <= 1'b0;
      up_rdata <= '0;
    end else begin
      up_wack <= io_wack | cm_wack;
      up_rack <= io_rack | cm_rack;
      up_rdata <= io_rdata | cm_rdata;
    end
  end

  // one block per request, never two
  a_one_wack: assert property (@(posedge up_clk) disable iff (!up_rstn) !(io_wack && cm_wack));
  a_one_rack: assert property (@(posedge up_clk) disable iff (!up_rstn) !(io_rack && cm_rack));

  // idle blocks keep their data at zero
  a_io_idle_zero: assert property (
    @(posedge up_clk) disable iff (!up_rstn) !io_rack |-> (io_rdata == '0));
  a_cm_idle_zero: assert property (
    @(posedge up_clk) disable iff (!up_rstn) !cm_rack |-> (cm_rdata == '0));

endmodule

//--- src/gpreg_top.sv
// ******************************
// top of the gp register subsystem, gpio and clock monitor on one up bus
// response arrives two up_clk cycles after the request
// ******************************

module gpreg_top (
  input  logic                             up_clk,
  input  logic                             up_rstn,
  // write request
  input  logic                             up_wreq,
  input  logic [gpreg_map_pkg::addr_w-1:0] up_waddr,
  input  logic [gpreg_map_pkg::data_w-1:0] up_wdata,
  output logic                             up_wack,
  // read request
  input  logic                             up_rreq,
  input  logic [gpreg_map_pkg::addr_w-1:0] up_raddr,
  output logic [gpreg_map_pkg::data_w-1:0] up_rdata,
  output logic                             up_rack,
  // gpio pins, buffers live outside
  input  logic [gpreg_map_pkg::data_w-1:0] up_gp_in,
  output logic [gpreg_map_pkg::data_w-1:0] up_gp_ioenb,
  output logic [gpreg_map_pkg::data_w-1:0] up_gp_out,
  // clock under measurement
  input  logic                             mon_clk
);

  // per block responses
  logic                             io_wack;
  logic                             io_rack;
  logic [gpreg_map_pkg::data_w-1:0] io_rdata;
  logic                             cm_wack;
  logic                             cm_rack;
  logic [gpreg_map_pkg::data_w-1:0] cm_rdata;

  gpreg_io i_io (
    .up_clk      (up_clk),
    .up_rstn     (up_rstn),
    .up_wreq     (up_wreq),
    .up_waddr    (up_waddr),
    .up_wdata    (up_wdata),
    .up_rreq     (up_rreq),
    .up_raddr    (up_raddr),
    .up_gp_in    (up_gp_in),
    .up_gp_ioenb (up_gp_ioenb),
    .up_gp_out   (up_gp_out),
    .io_wack     (io_wack),
    .io_rack     (io_rack),
    .io_rdata    (io_rdata)
  );

  gpreg_clk_mon i_clk_mon (
    .up_clk   (up_clk),
    .up_rstn  (up_rstn),
    .up_wreq  (up_wreq),
    .up_waddr (up_waddr),
    .up_wdata (up_wdata),
    .up_rreq  (up_rreq),
    .up_raddr (up_raddr),
    .mon_clk  (mon_clk),
    .cm_wack  (cm_wack),
    .cm_rack  (cm_rack),
    .cm_rdata (cm_rdata)
  );

  // second pipeline stage onto the bus
  gpreg_rd_merge i_rd_merge (
    .up_clk   (up_clk),
    .up_rstn  (up_rstn),
    .io_wack  (io_wack),
    .io_rack  (io_rack),
    .io_rdata (io_rdata),
    .cm_wack  (cm_wack),
    .cm_rack  (cm_rack),
    .cm_rdata (cm_rdata),
    .up_wack  (up_wack),
    .up_rack  (up_rack),
    .up_rdata (up_rdata)
  );

endmodule

//--- vlog.f
src/gpreg_map_pkg.sv
src/gpreg_clkmon_pkg.sv
src/gpreg_io.sv
src/gpreg_clk_mon.sv
src/gpreg_rd_merge.sv
src/gpreg_top.sv
sim/tb_clk_gen.sv
sim/tb_gpreg.sv
